/* common/gat_config.svh */
// =========================================================================
// Sizes, widths and memory depths of the graph attention feature layer
// Result memory layout and address widths of every BRAM
// =========================================================================

`ifndef GAT_CONFIG_SVH
`define GAT_CONFIG_SVH

// Word widths
`define DATA_WIDTH          8
`define COL_IDX_WIDTH       4
`define ROW_LEN_WIDTH       4
`define WH_DATA_WIDTH       20
`define COEF_WIDTH          32
`define NEW_FEATURE_WIDTH   32
`define H_DATA_WIDTH        (`DATA_WIDTH + `COL_IDX_WIDTH)

// Graph size
`define TOTAL_NODES         16
`define NUM_FEATURE_IN      11
`define NUM_FEATURE_OUT     4
`define H_NUM_SPARSE_DATA   64

// W followed by both halves of the attention vector
`define WEIGHT_DEPTH        (`NUM_FEATURE_IN * `NUM_FEATURE_OUT + 2 * `NUM_FEATURE_OUT)

// Result memory, one block of slots per node
`define FEAT_SLOTS          8
`define NEW_FEATURE_DEPTH   (`TOTAL_NODES * `FEAT_SLOTS)

// Multiply stage plus log2(NUM_FEATURE_OUT) adder levels
`define NUM_STAGES          3

// Address widths
`define H_DATA_ADDR_W       $clog2(`H_NUM_SPARSE_DATA)
`define NODE_INFO_ADDR_W    $clog2(`TOTAL_NODES)
`define WEIGHT_ADDR_W       $clog2(`WEIGHT_DEPTH)
`define NEW_FEATURE_ADDR_W  $clog2(`NEW_FEATURE_DEPTH)

`endif

/* common/gat_data_pkg.sv */
// =========================================================================
// Graph data word types: sparse H entries, row lengths
// Weight matrix, attention vector, WH rows and coefficients
// =========================================================================

`default_nettype none

`include "gat_config.svh"

package gat_data_pkg;

  typedef logic signed [`DATA_WIDTH-1:0]    weight_t;
  typedef logic signed [`WH_DATA_WIDTH-1:0] wh_t;
  typedef logic signed [`COEF_WIDTH-1:0]    coef_t;

  // One nonzero of H, value in the upper bits
  typedef struct packed {
    logic signed [`DATA_WIDTH-1:0] value;
    logic [`COL_IDX_WIDTH-1:0]     col_idx;
  } h_data_t;

  typedef struct packed {
    logic [`ROW_LEN_WIDTH-1:0] row_len;
  } node_info_t;

  // Entry (i, j) is weight[i][j]
  typedef weight_t [`NUM_FEATURE_IN-1:0][`NUM_FEATURE_OUT-1:0] weight_mat_t;

  // First half of the attention vector only
  typedef weight_t [`NUM_FEATURE_OUT-1:0] attn_vec_t;

  typedef wh_t [`NUM_FEATURE_OUT-1:0] wh_row_t;

endpackage

`default_nettype wire

/* common/gat_mem_pkg.sv */
// =========================================================================
// BRAM write-port bundles for H data, node info, weights and results
// =========================================================================

`default_nettype none

`include "gat_config.svh"

package gat_mem_pkg;

  typedef struct packed {
    logic [`H_DATA_WIDTH-1:0]  din;
    logic                      ena;
    logic                      wea;
    logic [`H_DATA_ADDR_W-1:0] addra;
  } h_data_wr_t;

  typedef struct packed {
    logic [`ROW_LEN_WIDTH-1:0]    din;
    logic                         ena;
    logic                         wea;
    logic [`NODE_INFO_ADDR_W-1:0] addra;
  } node_info_wr_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0]    din;
    logic                      ena;
    logic                      wea;
    logic [`WEIGHT_ADDR_W-1:0] addra;
  } wgt_wr_t;

  // Written by the core, read from outside
  typedef struct packed {
    logic [`NEW_FEATURE_WIDTH-1:0]  din;
    logic                           ena;
    logic                           wea;
    logic [`NEW_FEATURE_ADDR_W-1:0] addra;
  } feat_wr_t;

endpackage

`default_nettype wire

/* memory/bram_sdp.sv */
// =========================================================================
// Simple dual-port RAM, write port A and registered read port B
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

module bram_sdp #(
  parameter int  WIDTH  = 8,
  parameter int  DEPTH  = 16,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input  logic              clk,
  input  logic              ena,
  input  logic              wea,
  input  logic [ADDR_W-1:0] addra,
  input  logic [WIDTH-1:0]  din,
  input  logic [ADDR_W-1:0] addrb,
  output logic [WIDTH-1:0]  doutb
);

  logic [WIDTH-1:0] mem [DEPTH];

  // Read data appears one cycle after addrb
  always_ff @(posedge clk) begin
    if (ena && wea) begin
      mem[addra] <= din;
    end
    doutb <= mem[addrb];
  end

endmodule

`default_nettype wire

/* memory/memory_controller.sv */
// =========================================================================
// Memory controller with the four BRAMs of the layer
// Loads from outside, reads for the core, result write and readback
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "gat_config.svh"

module memory_controller
  import gat_data_pkg::*;
  import gat_mem_pkg::*;
(
  input  logic                           clk,
  input  h_data_wr_t                     h_data_wr,
  input  node_info_wr_t                  node_info_wr,
  input  wgt_wr_t                        wgt_wr,
  input  logic [`H_DATA_ADDR_W-1:0]      h_data_addrb,
  input  logic [`NODE_INFO_ADDR_W-1:0]   node_info_addrb,
  input  logic [`WEIGHT_ADDR_W-1:0]      wgt_addrb,
  output h_data_t                        h_data_dout,
  output node_info_t                     node_info_dout,
  output logic [`DATA_WIDTH-1:0]         wgt_dout,
  input  feat_wr_t                       feat_wr,
  input  logic [`NEW_FEATURE_ADDR_W-1:0] feat_bram_addrb,
  output logic [`NEW_FEATURE_WIDTH-1:0]  feat_bram_dout
);

  // =========================================================================
  // Input BRAMs, loaded from outside and read by the core
  // =========================================================================
  bram_sdp #(.WIDTH($bits(h_data_t)), .DEPTH(`H_NUM_SPARSE_DATA)) u_h_data_bram (
    .clk   (clk),
    .ena   (h_data_wr.ena),
    .wea   (h_data_wr.wea),
    .addra (h_data_wr.addra),
    .din   (h_data_wr.din),
    .addrb (h_data_addrb),
    .doutb (h_data_dout)
  );

  bram_sdp #(.WIDTH($bits(node_info_t)), .DEPTH(`TOTAL_NODES)) u_node_info_bram (
    .clk   (clk),
    .ena   (node_info_wr.ena),
    .wea   (node_info_wr.wea),
    .addra (node_info_wr.addra),
    .din   (node_info_wr.din),
    .addrb (node_info_addrb),
    .doutb (node_info_dout)
  );

  bram_sdp #(.WIDTH(`DATA_WIDTH), .DEPTH(`WEIGHT_DEPTH)) u_wgt_bram (
    .clk   (clk),
    .ena   (wgt_wr.ena),
    .wea   (wgt_wr.wea),
    .addra (wgt_wr.addra),
    .din   (wgt_wr.din),
    .addrb (wgt_addrb),
    .doutb (wgt_dout)
  );

  // =========================================================================
  // Result BRAM, written by the core and read from outside
  // =========================================================================
  bram_sdp #(.WIDTH(`NEW_FEATURE_WIDTH), .DEPTH(`NEW_FEATURE_DEPTH)) u_feat_bram (
    .clk   (clk),
    .ena   (feat_wr.ena),
    .wea   (feat_wr.wea),
    .addra (feat_wr.addra),
    .din   (feat_wr.din),
    .addrb (feat_bram_addrb),
    .doutb (feat_bram_dout)
  );

endmodule

`default_nettype wire

/* core/weight_loader.sv */
// =========================================================================
// Weight loader, copies W and the source attention half from the
// weight BRAM into registers before the multiply starts
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "gat_config.svh"

module weight_loader
  import gat_data_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wgt_bram_load_done,
  output logic [`WEIGHT_ADDR_W-1:0]  wgt_addrb,
  input  logic [`DATA_WIDTH-1:0]     wgt_dout,
  output weight_mat_t                weight,
  output attn_vec_t                  attn,
  output logic                       weights_loaded
);

  localparam int W_BITS    = $bits(weight_mat_t);
  localparam int LOAD_BITS = W_BITS + $bits(attn_vec_t);
  localparam int LAST_ADDR = `NUM_FEATURE_IN * `NUM_FEATURE_OUT + `NUM_FEATURE_OUT - 1;

  logic                 busy;
  logic                 rd_valid;
  logic                 rd_last;
  logic [LOAD_BITS-1:0] load_sr;

  // Address walk over W then the first attention entries
  always_ff @(posedge clk) begin
    if (rst) begin
      wgt_addrb      <= '0;
      busy           <= 1'b0;
      rd_valid       <= 1'b0;
      rd_last        <= 1'b0;
      weights_loaded <= 1'b0;
    end else begin
      rd_valid <= busy;
      rd_last  <= busy && (wgt_addrb == LAST_ADDR);
      if (rd_last) begin
        weights_loaded <= 1'b1;
      end
      if (busy) begin
        if (wgt_addrb == LAST_ADDR) begin
          busy <= 1'b0;
        end else begin
          wgt_addrb <= wgt_addrb + 1'b1;
        end
      end else if (wgt_bram_load_done && !rd_valid && !weights_loaded) begin
        busy <= 1'b1;
      end
    end
  end

  // Words shift in from the top, so address k ends at bits k*DATA_WIDTH
  always_ff @(posedge clk) begin
    if (rd_valid) begin
      load_sr <= {wgt_dout, load_sr[LOAD_BITS-1:`DATA_WIDTH]};
    end
  end

  assign weight = load_sr[W_BITS-1:0];
  assign attn   = load_sr[LOAD_BITS-1:W_BITS];

endmodule

`default_nettype wire

/* core/spmm.sv */
// =========================================================================
// Sparse row times dense W, one node at a time
// Reads the row length, then each nonzero, and accumulates the WH row
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "gat_config.svh"

module spmm
  import gat_data_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          weights_loaded,
  input  logic                          h_data_bram_load_done,
  input  logic                          h_node_info_bram_load_done,
  output logic [`NODE_INFO_ADDR_W-1:0]  node_info_addrb,
  input  node_info_t                    node_info_dout,
  output logic [`H_DATA_ADDR_W-1:0]     h_data_addrb,
  input  h_data_t                       h_data_dout,
  input  weight_mat_t                   weight,
  input  logic                          feat_busy,
  output wh_row_t                       wh_row,
  output logic [`NODE_INFO_ADDR_W-1:0]  wh_node,
  output logic                          wh_valid,
  output logic                          rows_done
);

  localparam int LAST_NODE = `TOTAL_NODES - 1;

  typedef enum logic [2:0] {
    S_IDLE, S_LEN_RD, S_LEN, S_H_RD, S_H_ACC, S_EMIT, S_DONE
  } state_t;

  state_t                       state;
  logic [`NODE_INFO_ADDR_W-1:0] node;
  logic [`ROW_LEN_WIDTH-1:0]    row_len;
  logic [`ROW_LEN_WIDTH-1:0]    entry_cnt;
  wh_row_t                      mac_sum;

  assign node_info_addrb = node;

  // Value times the addressed W row, added to the running sums
  always_comb begin
    for (int j = 0; j < `NUM_FEATURE_OUT; j++) begin
      mac_sum[j] = wh_row[j] + $signed(h_data_dout.value) *
                   $signed(weight[h_data_dout.col_idx][j]);
    end
  end

  // =========================================================================
  // Control FSM, two cycles per nonzero for the BRAM read
  // =========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      node         <= '0;
      h_data_addrb <= '0;
      wh_valid     <= 1'b0;
      rows_done    <= 1'b0;
    end else begin
      wh_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (weights_loaded && h_data_bram_load_done && h_node_info_bram_load_done) begin
            state <= S_LEN_RD;
          end
        end
        S_LEN_RD: state <= S_LEN;
        S_LEN:    state <= (node_info_dout.row_len == '0) ? S_EMIT : S_H_RD;
        S_H_RD:   state <= S_H_ACC;
        S_H_ACC: begin
          h_data_addrb <= h_data_addrb + 1'b1;
          state        <= (entry_cnt + 1'b1 == row_len) ? S_EMIT : S_H_RD;
        end
        S_EMIT: begin
          // Hold the row until the writer has drained the previous one
          if (!feat_busy) begin
            wh_valid <= 1'b1;
            if (node == LAST_NODE) begin
              rows_done <= 1'b1;
              state     <= S_DONE;
            end else begin
              node  <= node + 1'b1;
              state <= S_LEN_RD;
            end
          end
        end
        default: state <= S_DONE;
      endcase
    end
  end

  // Row accumulators and per-row bookkeeping
  always_ff @(posedge clk) begin
    if (state == S_LEN) begin
      row_len   <= node_info_dout.row_len;
      entry_cnt <= '0;
      wh_row    <= '0;
    end else if (state == S_H_ACC) begin
      entry_cnt <= entry_cnt + 1'b1;
      wh_row    <= mac_sum;
    end
    if (state == S_EMIT && !feat_busy) begin
      wh_node <= node;
    end
  end

endmodule

`default_nettype wire

/* core/dmvm.sv */
// =========================================================================
// Pipelined dot product of a WH row with the source attention half
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "gat_config.svh"

module dmvm
  import gat_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  wh_row_t   wh_row,
  input  logic      wh_valid,
  input  attn_vec_t attn,
  output coef_t     coef,
  output logic      coef_valid
);

  localparam int N = `NUM_FEATURE_OUT;

  // Level 0 holds the products, each later level halves the count
  coef_t                  tree [`NUM_STAGES][N];
  logic [`NUM_STAGES-1:0] stage_vld;

  // Operands widened first so the product keeps all of its bits
  always_ff @(posedge clk) begin
    for (int j = 0; j < N; j++) begin
      tree[0][j] <= coef_t'($signed(attn[j])) * coef_t'($signed(wh_row[j]));
    end
    for (int l = 1; l < `NUM_STAGES; l++) begin
      for (int j = 0; j < (N >> l); j++) begin
        tree[l][j] <= tree[l-1][2*j] + tree[l-1][2*j+1];
      end
    end
  end

  // Valid travels beside the data, a new row may enter every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_vld <= '0;
    end else begin
      stage_vld <= {stage_vld[`NUM_STAGES-2:0], wh_valid};
    end
  end

  assign coef       = tree[`NUM_STAGES-1][0];
  assign coef_valid = stage_vld[`NUM_STAGES-1];

endmodule

`default_nettype wire

/* rtl/feature_writer.sv */
// =========================================================================
// Result writer, WH slots of a node then its coefficient slot
// Raises gat_ready after the last node is written
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "gat_config.svh"

module feature_writer
  import gat_data_pkg::*;
  import gat_mem_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  wh_row_t                      wh_row,
  input  logic [`NODE_INFO_ADDR_W-1:0] wh_node,
  input  logic                         wh_valid,
  input  coef_t                        coef,
  input  logic                         coef_valid,
  input  logic                         rows_done,
  output feat_wr_t                     feat_wr,
  output logic                         feat_busy,
  output logic                         gat_ready
);

  localparam int SLOT_W = $clog2(`FEAT_SLOTS);
  localparam int IDX_W  = $clog2(`NUM_FEATURE_OUT);
  localparam int ADDR_W = `NEW_FEATURE_ADDR_W;
  localparam int FEAT_W = `NEW_FEATURE_WIDTH;

  typedef enum logic [1:0] {S_IDLE, S_SLOTS, S_COEF} state_t;

  state_t                       state;
  wh_row_t                      row_q;
  logic [`NODE_INFO_ADDR_W-1:0] node_q;
  logic [SLOT_W-1:0]            slot;
  coef_t                        coef_q;
  logic                         coef_held;
  logic                         coef_wr;

  // Coefficient may arrive while WH slots are still being written
  assign coef_wr   = (state == S_COEF) && coef_held;
  assign feat_busy = wh_valid || (state != S_IDLE);

  always_comb begin
    feat_wr.ena   = (state == S_SLOTS) || coef_wr;
    feat_wr.wea   = feat_wr.ena;
    feat_wr.addra = ADDR_W'(node_q * `FEAT_SLOTS + slot);
    feat_wr.din   = coef_wr ? coef_q : FEAT_W'($signed(row_q[slot[IDX_W-1:0]]));
  end

  // =========================================================================
  // Slot sequencing
  // =========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      slot      <= '0;
      coef_held <= 1'b0;
      gat_ready <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (wh_valid) begin
            slot  <= '0;
            state <= S_SLOTS;
          end
        end
        S_SLOTS: begin
          // Last WH slot steps the counter onto the coefficient slot
          slot <= slot + 1'b1;
          if (slot == SLOT_W'(`NUM_FEATURE_OUT - 1)) begin
            state <= S_COEF;
          end
        end
        S_COEF: begin
          if (coef_held) begin
            state <= S_IDLE;
            if (rows_done) begin
              gat_ready <= 1'b1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
      if (coef_valid) begin
        coef_held <= 1'b1;
      end else if (coef_wr) begin
        coef_held <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && wh_valid) begin
      row_q  <= wh_row;
      node_q <= wh_node;
    end
    if (coef_valid) begin
      coef_q <= coef;
    end
  end

endmodule

`default_nettype wire

/* rtl/gat_top.sv */
// =========================================================================
// Top level of the feature layer, memory controller and core blocks
// =========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "gat_config.svh"

module gat_top
  import gat_data_pkg::*;
  import gat_mem_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           h_data_bram_load_done,
  input  logic                           h_node_info_bram_load_done,
  input  logic                           wgt_bram_load_done,
  input  h_data_wr_t                     h_data_wr,
  input  node_info_wr_t                  node_info_wr,
  input  wgt_wr_t                        wgt_wr,
  input  logic [`NEW_FEATURE_ADDR_W-1:0] feat_bram_addrb,
  output logic [`NEW_FEATURE_WIDTH-1:0]  feat_bram_dout,
  output logic                           gat_ready
);

  // BRAM read side
  logic [`H_DATA_ADDR_W-1:0]    h_data_addrb;
  logic [`NODE_INFO_ADDR_W-1:0] node_info_addrb;
  logic [`WEIGHT_ADDR_W-1:0]    wgt_addrb;
  h_data_t                      h_data_dout;
  node_info_t                   node_info_dout;
  logic [`DATA_WIDTH-1:0]       wgt_dout;

  // Core datapath
  weight_mat_t                  weight;
  attn_vec_t                    attn;
  logic                         weights_loaded;
  wh_row_t                      wh_row;
  logic [`NODE_INFO_ADDR_W-1:0] wh_node;
  logic                         wh_valid;
  logic                         rows_done;
  coef_t                        coef;
  logic                         coef_valid;
  logic                         feat_busy;
  feat_wr_t                     feat_wr;

  memory_controller u_memory_controller (.*);

  weight_loader u_weight_loader (.*);

  spmm u_spmm (.*);

  dmvm u_dmvm (.*);

  feature_writer u_feature_writer (.*);

endmodule

`default_nettype wire

/* tb/gat_tb.sv */
// ==========================================================================
// Testbench for the graph attention feature layer
// Random sparse H, W and attention loaded through the write ports
// Model of WH rows and coefficients, readback checks of the result BRAM
// ==========================================================================

`timescale 1ns/1ns
`default_nettype none

`include "gat_config.svh"

module gat_tb
  import gat_mem_pkg::*;
();

  localparam int H_AW          = `H_DATA_ADDR_W;
  localparam int NODE_AW       = `NODE_INFO_ADDR_W;
  localparam int WGT_AW        = `WEIGHT_ADDR_W;
  localparam int FEAT_AW       = `NEW_FEATURE_ADDR_W;
  localparam int N_OUT         = `NUM_FEATURE_OUT;
  localparam int ATTN_BASE     = `NUM_FEATURE_IN * `NUM_FEATURE_OUT;
  localparam int IDLE_CYCLES   = 50;
  localparam int HOLD_CYCLES   = 20;
  localparam int READY_TIMEOUT = 5000;

  logic                          clk;
  logic                          rst;
  logic                          h_data_bram_load_done;
  logic                          h_node_info_bram_load_done;
  logic                          wgt_bram_load_done;
  h_data_wr_t                    h_data_wr;
  node_info_wr_t                 node_info_wr;
  wgt_wr_t                       wgt_wr;
  logic [FEAT_AW-1:0]            feat_bram_addrb;
  logic [`NEW_FEATURE_WIDTH-1:0] feat_bram_dout;
  logic                          gat_ready;

  gat_top gat_top_i (.*);

  always #10 clk = ~clk;

  // ==========================================================================
  // Stimulus and model state
  // ==========================================================================
  integer                          seed;
  int                              row_len_m [`TOTAL_NODES];
  logic signed [`DATA_WIDTH-1:0]   h_val_m   [`H_NUM_SPARSE_DATA];
  logic [`COL_IDX_WIDTH-1:0]       h_col_m   [`H_NUM_SPARSE_DATA];
  logic signed [`DATA_WIDTH-1:0]   wgt_m     [`WEIGHT_DEPTH];
  logic signed [`WH_DATA_WIDTH-1:0] wh_m     [`TOTAL_NODES][N_OUT];
  logic signed [`COEF_WIDTH-1:0]   coef_m    [`TOTAL_NODES];
  int                              checks;
  int                              errors;
  int                              checks_mark;
  int                              errors_mark;
  bit                              timed_out;

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic start_test();
    checks_mark = checks;
    errors_mark = errors;
  endtask

  task automatic report_test(input string name);
    $display("test %-18s %0d checks, %0d errors", name, checks - checks_mark,
             errors - errors_mark);
  endtask

  // Node 0 stays empty, the rest get 0 to 4 nonzeros
  task automatic build_stimulus();
    int k;
    k = 0;
    for (int a = 0; a < `H_NUM_SPARSE_DATA; a++) begin
      h_val_m[a] = '0;
      h_col_m[a] = '0;
    end
    for (int n = 0; n < `TOTAL_NODES; n++) begin
      row_len_m[n] = (n == 0) ? 0 : (($random(seed) & 32'hffff) % 5);
      for (int e = 0; e < row_len_m[n]; e++) begin
        h_col_m[k] = 4'((($random(seed) & 32'hffff) % `NUM_FEATURE_IN));
        h_val_m[k] = 8'($random(seed));
        k++;
      end
    end
    for (int a = 0; a < `WEIGHT_DEPTH; a++) begin
      wgt_m[a] = 8'($random(seed));
    end
  endtask

  // WH in 20 bits, then dot product with the first attention half
  task automatic compute_model();
    int k;
    int sum;
    int csum;
    k = 0;
    for (int n = 0; n < `TOTAL_NODES; n++) begin
      csum = 0;
      for (int j = 0; j < N_OUT; j++) begin
        sum = 0;
        for (int e = 0; e < row_len_m[n]; e++) begin
          sum = sum + h_val_m[k+e] * wgt_m[h_col_m[k+e] * N_OUT + j];
        end
        wh_m[n][j] = 20'(sum);
        csum = csum + wgt_m[ATTN_BASE + j] * wh_m[n][j];
      end
      coef_m[n] = csum;
      k = k + row_len_m[n];
    end
  endtask

  task automatic load_memories();
    for (int a = 0; a < `H_NUM_SPARSE_DATA; a++) begin
      h_data_wr.ena   = 1'b1;
      h_data_wr.wea   = 1'b1;
      h_data_wr.addra = H_AW'(a);
      h_data_wr.din   = {h_val_m[a], h_col_m[a]};
      next_cycle();
    end
    h_data_wr = '0;
    for (int n = 0; n < `TOTAL_NODES; n++) begin
      node_info_wr.ena   = 1'b1;
      node_info_wr.wea   = 1'b1;
      node_info_wr.addra = NODE_AW'(n);
      node_info_wr.din   = 4'(row_len_m[n]);
      next_cycle();
    end
    node_info_wr = '0;
    for (int a = 0; a < `WEIGHT_DEPTH; a++) begin
      wgt_wr.ena   = 1'b1;
      wgt_wr.wea   = 1'b1;
      wgt_wr.addra = WGT_AW'(a);
      wgt_wr.din   = wgt_m[a];
      next_cycle();
    end
    wgt_wr = '0;
  endtask

  // Read data is valid one cycle after the address
  task automatic read_result(input int addr, output logic [31:0] data);
    feat_bram_addrb = FEAT_AW'(addr);
    next_cycle();
    data = feat_bram_dout;
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    logic [31:0] data;
    int          addr;
    int          cnt;
    clk                        = 1'b0;
    rst                        = 1'b1;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    h_data_wr                  = '0;
    node_info_wr               = '0;
    wgt_wr                     = '0;
    feat_bram_addrb            = '0;
    checks                     = 0;
    errors                     = 0;
    timed_out                  = 1'b0;
    seed                       = 32'ha3c4;

    build_stimulus();
    compute_model();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    start_test();
    for (int c = 0; c < IDLE_CYCLES; c++) begin
      check_value("gat_ready", 32'(gat_ready), 32'h0);
      next_cycle();
    end
    report_test("idle_before_load");

    load_memories();
    h_data_bram_load_done      = 1'b1;
    h_node_info_bram_load_done = 1'b1;
    wgt_bram_load_done         = 1'b1;

    start_test();
    cnt = 0;
    while (!gat_ready && cnt < READY_TIMEOUT) begin
      next_cycle();
      cnt++;
    end
    if (!gat_ready) begin
      timed_out = 1'b1;
      $display("timeout: gat_ready did not rise within %0d cycles", READY_TIMEOUT);
    end else begin
      for (int c = 0; c < HOLD_CYCLES; c++) begin
        next_cycle();
        check_value("gat_ready", 32'(gat_ready), 32'h1);
      end
    end
    report_test("ready_rise_hold");

    if (!timed_out) begin
      start_test();
      for (int n = 0; n < `TOTAL_NODES; n++) begin
        for (int j = 0; j < N_OUT; j++) begin
          addr = n * `FEAT_SLOTS + j;
          read_result(addr, data);
          check_value($sformatf("feat_bram_dout[%0d]", addr), data,
                      {{12{wh_m[n][j][19]}}, wh_m[n][j]});
        end
      end
      report_test("wh_slots");

      start_test();
      for (int n = 0; n < `TOTAL_NODES; n++) begin
        addr = n * `FEAT_SLOTS + N_OUT;
        read_result(addr, data);
        check_value($sformatf("feat_bram_dout[%0d]", addr), data, coef_m[n]);
      end
      report_test("coef_slots");

      // Empty row gives zero WH and a zero coefficient
      start_test();
      for (int s = 0; s <= N_OUT; s++) begin
        read_result(s, data);
        check_value($sformatf("feat_bram_dout[%0d]", s), data, 32'h0);
      end
      report_test("zero_length_node");
    end

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/gat_data_pkg.sv
common/gat_mem_pkg.sv
memory/bram_sdp.sv
memory/memory_controller.sv
core/weight_loader.sv
core/spmm.sv
core/dmvm.sv
rtl/feature_writer.sv
rtl/gat_top.sv
tb/gat_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the feature layer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module gat_tb -o gat_sim
./obj_dir/gat_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
  exit 0
else
  exit 1
fi
